/* source/riscv_isa_pkg.sv */
package riscv_isa_pkg;

  // major opcodes, bits [6:0] of a 32-bit instruction
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011; // beq, bne, blt ...
  localparam logic [6:0] OPC_FENCE  = 7'b0001111; // fence, fence.i
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // ecall, ebreak, csr*
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP     = 7'b0110011; // register-register alu ops

  // funct3 values under OPC_SYSTEM
  localparam logic [2:0] F3_PRIV   = 3'b000; // ecall / ebreak
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // field positions (lsb of each field)
  localparam int unsigned RD_LSB  = 7;
  localparam int unsigned F3_LSB  = 12;
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_LSB = 20;

  localparam int unsigned REG_IDX_W        = 5;  // logical register index width
  localparam int unsigned NUM_LOGICAL_REGS = 32; // x0 .. x31
  localparam int unsigned XLEN             = 32; // instruction and address width

endpackage

/* source/shuffle_buf_pkg.sv */
package shuffle_buf_pkg;

  // number of slots in the shuffle ring
  localparam int unsigned DEPTH = 5;

  // head / tail pointer width
  localparam int unsigned PTR_W = $clog2(DEPTH);

  // pointer value of the last slot, wraps back to 0 after it
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  // physical register file seen by the rename stage
  localparam int unsigned NUM_PHYS_REGS = 64;
  localparam int unsigned PHYS_IDX_W    = $clog2(NUM_PHYS_REGS); // 6 bits

endpackage

/* source/instr_class_decode.sv */
`timescale 1ns/100ps

module instr_class_decode (
  input  logic [riscv_isa_pkg::XLEN-1:0]      instr_i,
  output logic                                ctrl_flow_o, // may redirect the pc
  output logic                                has_rd_o,
  output logic                                has_rs1_o,
  output logic                                has_rs2_o,
  output logic [riscv_isa_pkg::REG_IDX_W-1:0] rd_o,
  output logic [riscv_isa_pkg::REG_IDX_W-1:0] rs1_o,
  output logic [riscv_isa_pkg::REG_IDX_W-1:0] rs2_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_jal, is_jalr, is_branch, is_fence, is_store;
  logic       is_lui, is_auipc, is_op;
  logic       is_priv;    // ecall / ebreak
  logic       is_csr_imm; // csr forms with a uimm in place of rs1

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[riscv_isa_pkg::F3_LSB +: 3];

  assign is_jal    = (opcode == riscv_isa_pkg::OPC_JAL);
  assign is_jalr   = (opcode == riscv_isa_pkg::OPC_JALR);
  assign is_branch = (opcode == riscv_isa_pkg::OPC_BRANCH);
  assign is_fence  = (opcode == riscv_isa_pkg::OPC_FENCE);
  assign is_store  = (opcode == riscv_isa_pkg::OPC_STORE);
  assign is_lui    = (opcode == riscv_isa_pkg::OPC_LUI);
  assign is_auipc  = (opcode == riscv_isa_pkg::OPC_AUIPC);
  assign is_op     = (opcode == riscv_isa_pkg::OPC_OP);

  assign is_priv = (opcode == riscv_isa_pkg::OPC_SYSTEM) && (funct3 == riscv_isa_pkg::F3_PRIV);

  assign is_csr_imm = (opcode == riscv_isa_pkg::OPC_SYSTEM) &&
                      ((funct3 == riscv_isa_pkg::F3_CSRRWI) ||
                       (funct3 == riscv_isa_pkg::F3_CSRRSI) ||
                       (funct3 == riscv_isa_pkg::F3_CSRRCI));

  // anything that can change the pc, fence included so intake waits on it too
  assign ctrl_flow_o = is_jal || is_jalr || is_branch || is_fence || is_priv;

  assign has_rd_o  = !(is_branch || is_store || is_fence || is_priv);
  assign has_rs1_o = !(is_lui || is_auipc || is_jal || is_fence || is_priv || is_csr_imm);
  assign has_rs2_o = is_branch || is_store || is_op;

  // fixed field positions, consumers ignore them when the has_* flag is low
  assign rd_o  = instr_i[riscv_isa_pkg::RD_LSB  +: riscv_isa_pkg::REG_IDX_W];
  assign rs1_o = instr_i[riscv_isa_pkg::RS1_LSB +: riscv_isa_pkg::REG_IDX_W];
  assign rs2_o = instr_i[riscv_isa_pkg::RS2_LSB +: riscv_isa_pkg::REG_IDX_W];

  // the word feeds hold and rename state, an x here would poison both
  always_comb begin
    assert final (!$isunknown(instr_i))
      else $error("instr_class_decode: instr_i has unknown bits %h", instr_i);
  end

endmodule

/* source/branch_hold_ctrl.sv */
`timescale 1ns/100ps

module branch_hold_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           branch_i,    // core redirects the pc
  input  logic                           ready_i,     // decode stage can take the head
  input  logic                           push_i,      // instruction accepted this cycle
  input  logic                           ctrl_flow_i, // accepted instruction may redirect
  input  logic [riscv_isa_pkg::XLEN-1:0] push_addr_i,
  input  logic                           pop_i,       // head handed to decode
  input  logic [riscv_isa_pkg::XLEN-1:0] head_addr_i,
  output logic                           hold_o,      // stop intake from fetch
  output logic                           resolved_o   // held instruction retired, no redirect
);

  logic                           hold_d;
  logic [riscv_isa_pkg::XLEN-1:0] last_addr_q; // pc of the last accepted control-flow instr
  logic                           popped_d, popped_q;

  // the held instruction left the buffer this cycle
  assign popped_d = pop_i && hold_o && (head_addr_i == last_addr_q);

  // decode keeps ready_i low after a taken redirect, so ready now means fall-through
  assign resolved_o = popped_q && ready_i;

  always_comb begin
    hold_d = hold_o;
    if (branch_i || resolved_o) begin
      hold_d = 1'b0;
    end
    // set after clear, a control-flow instr right behind another keeps the hold
    if (push_i && ctrl_flow_i) begin
      hold_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_o   <= 1'b0;
      popped_q <= 1'b0;
    end else begin
      hold_o   <= hold_d;
      popped_q <= popped_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && ctrl_flow_i) begin
      last_addr_q <= push_addr_i; // compared against the head on every pop while held
    end
  end

  // a redirect always leaves intake open on the next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    branch_i && !(push_i && ctrl_flow_i) |=> !hold_o)
    else $error("branch_hold_ctrl: hold_o set after branch_i without control-flow push");

endmodule

/* source/inst_ring_buffer.sv */
`timescale 1ns/100ps

module inst_ring_buffer (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                fetch_valid_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]      fetch_instr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]      fetch_addr_i,
  input  logic                                branch_i,
  input  logic                                ready_i,
  input  logic                                hold_i,     // intake stopped behind a branch
  input  logic                                resolved_i, // hold ends this cycle
  output logic                                fetch_ready_o,
  output logic                                push_o,
  output logic                                pop_o,
  output logic [shuffle_buf_pkg::PTR_W-1:0]   head_ptr_o, // oldest entry
  output logic [shuffle_buf_pkg::PTR_W-1:0]   tail_ptr_o, // next free slot
  output logic                                valid_o,
  output logic [riscv_isa_pkg::XLEN-1:0]      rdata_o,
  output logic [riscv_isa_pkg::XLEN-1:0]      addr_o
);

  logic [shuffle_buf_pkg::DEPTH-1:0] slot_valid_q;
  logic [riscv_isa_pkg::XLEN-1:0]    slot_addr_q  [shuffle_buf_pkg::DEPTH];
  logic [riscv_isa_pkg::XLEN-1:0]    slot_instr_q [shuffle_buf_pkg::DEPTH];
  logic                              full, not_empty;

  // pointers count 0 .. DEPTH-1 and wrap, DEPTH need not be a power of two
  function automatic logic [shuffle_buf_pkg::PTR_W-1:0] ptr_inc(
    input logic [shuffle_buf_pkg::PTR_W-1:0] ptr
  );
    if (ptr == shuffle_buf_pkg::LAST_PTR) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full      = &slot_valid_q;
  assign not_empty = |slot_valid_q;

  // release only a full ring, or a partial one while waiting on a branch
  assign valid_o = full || (not_empty && hold_i);
  assign pop_o   = ready_i && valid_o;

  // a full ring still takes one when the head leaves in the same cycle
  assign push_o = fetch_valid_i && !branch_i && (!full || pop_o) && (!hold_i || resolved_i);
  assign fetch_ready_o = push_o;

  assign rdata_o = slot_instr_q[head_ptr_o];
  assign addr_o  = slot_addr_q[head_ptr_o];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= '0;
      head_ptr_o   <= '0;
      tail_ptr_o   <= '0;
    end else begin
      // pop first, head and tail may name the same slot when full
      if (pop_o) begin
        slot_valid_q[head_ptr_o] <= 1'b0;
        head_ptr_o               <= ptr_inc(head_ptr_o);
      end
      if (push_o) begin
        slot_valid_q[tail_ptr_o] <= 1'b1; // later nba wins over the pop clear
        tail_ptr_o               <= ptr_inc(tail_ptr_o);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_o) begin
      slot_addr_q[tail_ptr_o]  <= fetch_addr_i;
      slot_instr_q[tail_ptr_o] <= fetch_instr_i;
    end
  end

  // a push without pop grows the occupancy by exactly one, never wraps over an entry
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o && !pop_o |=> $countones(slot_valid_q) == $past($countones(slot_valid_q)) + 1)
    else $error("inst_ring_buffer: push into full buffer without pop");

  // head pointer must sit on a live entry whenever one is offered
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> slot_valid_q[head_ptr_o])
    else $error("inst_ring_buffer: valid_o with empty head slot");

endmodule

/* source/reg_rename.sv */
`timescale 1ns/100ps

module reg_rename (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   push_i,
  input  logic                                   pop_i,
  input  logic [shuffle_buf_pkg::PTR_W-1:0]      head_ptr_i,
  input  logic [shuffle_buf_pkg::PTR_W-1:0]      tail_ptr_i,
  input  logic                                   has_rd_i,
  input  logic                                   has_rs1_i,
  input  logic                                   has_rs2_i,
  input  logic [riscv_isa_pkg::REG_IDX_W-1:0]    rd_i,
  input  logic [riscv_isa_pkg::REG_IDX_W-1:0]    rs1_i,
  input  logic [riscv_isa_pkg::REG_IDX_W-1:0]    rs2_i,
  output logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] rd_phys_o,
  output logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] rs1_phys_o,
  output logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] rs2_phys_o
);

  // logical -> physical map, one entry per architectural register
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] map_q [riscv_isa_pkg::NUM_LOGICAL_REGS];
  logic [shuffle_buf_pkg::NUM_PHYS_REGS-1:0] reserved_q; // same info as map_q, one-hot form

  // per slot renamed indices, read out at the head
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0]    slot_rd_q  [shuffle_buf_pkg::DEPTH];
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0]    slot_rs1_q [shuffle_buf_pkg::DEPTH];
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0]    slot_rs2_q [shuffle_buf_pkg::DEPTH];
  logic [shuffle_buf_pkg::NUM_PHYS_REGS-1:0] slot_use_q [shuffle_buf_pkg::DEPTH];

  logic [shuffle_buf_pkg::NUM_PHYS_REGS-1:0] in_use;
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0]    free_idx;  // lowest unused physical reg
  logic                                      alloc_en;  // new destination this cycle
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0]    new_rd, new_rs1, new_rs2;
  logic [shuffle_buf_pkg::NUM_PHYS_REGS-1:0] new_use;

  // a reg can be unmapped yet still read by a buffered instr, so or in every slot
  always_comb begin
    in_use = reserved_q;
    for (int s = 0; s < shuffle_buf_pkg::DEPTH; s++) begin
      in_use |= slot_use_q[s]; // popped slots are already zero
    end
    free_idx = '0;
    for (int p = shuffle_buf_pkg::NUM_PHYS_REGS - 1; p >= 0; p--) begin
      if (!in_use[p]) begin
        free_idx = p[shuffle_buf_pkg::PHYS_IDX_W-1:0]; // ends on the lowest free one
      end
    end
  end

  // x0 never gets a new register, it stays on physical 0
  assign alloc_en = push_i && has_rd_i && (rd_i != '0);

  assign new_rd  = alloc_en  ? free_idx     : '0;
  assign new_rs1 = has_rs1_i ? map_q[rs1_i] : '0; // map before this push, rd == rs1 reads old
  assign new_rs2 = has_rs2_i ? map_q[rs2_i] : '0;

  always_comb begin
    new_use          = '0;
    new_use[new_rd]  = 1'b1;
    new_use[new_rs1] = 1'b1;
    new_use[new_rs2] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < riscv_isa_pkg::NUM_LOGICAL_REGS; i++) begin
        map_q[i] <= i[shuffle_buf_pkg::PHYS_IDX_W-1:0]; // identity map
      end
      for (int p = 0; p < shuffle_buf_pkg::NUM_PHYS_REGS; p++) begin
        reserved_q[p] <= (p < riscv_isa_pkg::NUM_LOGICAL_REGS);
      end
      for (int s = 0; s < shuffle_buf_pkg::DEPTH; s++) begin
        slot_use_q[s] <= '0;
      end
    end else begin
      if (pop_i) begin
        slot_use_q[head_ptr_i] <= '0;
      end
      if (push_i) begin
        slot_use_q[tail_ptr_i] <= new_use; // overrides the clear when head == tail
      end
      if (alloc_en) begin
        reserved_q[map_q[rd_i]] <= 1'b0; // old mapping released
        reserved_q[free_idx]    <= 1'b1;
        map_q[rd_i]             <= free_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      slot_rd_q[tail_ptr_i]  <= new_rd;
      slot_rs1_q[tail_ptr_i] <= new_rs1;
      slot_rs2_q[tail_ptr_i] <= new_rs2;
    end
  end

  // same slot as the ring buffer head
  assign rd_phys_o  = slot_rd_q[head_ptr_i];
  assign rs1_phys_o = slot_rs1_q[head_ptr_i];
  assign rs2_phys_o = slot_rs2_q[head_ptr_i];

  // allocation takes a free register and leaves it reserved afterwards
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_en |=> !$past(reserved_q[free_idx]) && reserved_q[$past(free_idx)])
    else $error("reg_rename: allocated physical register was already reserved");

endmodule

/* source/fetch_shuffle_top.sv */
`timescale 1ns/100ps

module fetch_shuffle_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   fetch_valid_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]         fetch_instr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]         fetch_addr_i,
  output logic                                   fetch_ready_o,
  input  logic                                   branch_i, // redirect from execute
  input  logic                                   ready_i,
  output logic                                   valid_o,
  output logic [riscv_isa_pkg::XLEN-1:0]         rdata_o,
  output logic [riscv_isa_pkg::XLEN-1:0]         addr_o,
  output logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] rd_phys_o,
  output logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] rs1_phys_o,
  output logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] rs2_phys_o
);

  logic                                ctrl_flow, has_rd, has_rs1, has_rs2;
  logic [riscv_isa_pkg::REG_IDX_W-1:0] rd, rs1, rs2;
  logic                                hold, resolved;
  logic                                push, pop;
  logic [shuffle_buf_pkg::PTR_W-1:0]   head_ptr, tail_ptr;

  instr_class_decode u_decode (
    .instr_i     (fetch_instr_i), // classified at intake
    .ctrl_flow_o (ctrl_flow),
    .has_rd_o    (has_rd),
    .has_rs1_o   (has_rs1),
    .has_rs2_o   (has_rs2),
    .rd_o        (rd),
    .rs1_o       (rs1),
    .rs2_o       (rs2)
  );

  branch_hold_ctrl u_hold (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .branch_i    (branch_i),
    .ready_i     (ready_i),
    .push_i      (push),
    .ctrl_flow_i (ctrl_flow),
    .push_addr_i (fetch_addr_i),
    .pop_i       (pop),
    .head_addr_i (addr_o),
    .hold_o      (hold),
    .resolved_o  (resolved)
  );

  inst_ring_buffer u_ring (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_addr_i  (fetch_addr_i),
    .branch_i      (branch_i),
    .ready_i       (ready_i),
    .hold_i        (hold),
    .resolved_i    (resolved),
    .fetch_ready_o (fetch_ready_o),
    .push_o        (push),
    .pop_o         (pop),
    .head_ptr_o    (head_ptr),
    .tail_ptr_o    (tail_ptr),
    .valid_o       (valid_o),
    .rdata_o       (rdata_o),
    .addr_o        (addr_o)
  );

  reg_rename u_rename (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push_i     (push),
    .pop_i      (pop),
    .head_ptr_i (head_ptr),
    .tail_ptr_i (tail_ptr), // slot written on the same edge as the ring
    .has_rd_i   (has_rd),
    .has_rs1_i  (has_rs1),
    .has_rs2_i  (has_rs2),
    .rd_i       (rd),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_phys_o  (rd_phys_o),
    .rs1_phys_o (rs1_phys_o),
    .rs2_phys_o (rs2_phys_o)
  );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
  input  logic rst_req_i, // restarts the reset sequence
  output logic clk_o,
  output logic rst_no
);

  int unsigned rise_cnt = 0; // rising edges seen under reset

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
  end

  always #20 clk_o = ~clk_o; // 40 ns period

  always @(posedge clk_o or posedge rst_req_i) begin
    if (rst_req_i) begin
      rise_cnt <= 0;
    end else if (rise_cnt < 3) begin
      rise_cnt <= rise_cnt + 1;
    end
  end

  // release on a falling edge, away from the sampling edge
  always @(negedge clk_o or posedge rst_req_i) begin
    if (rst_req_i) begin
      rst_no <= 1'b0;
    end else begin
      rst_no <= (rise_cnt >= 3);
    end
  end

endmodule

/* dv/tb_fetch_shuffle.sv */
`timescale 1ns/100ps

module tb_fetch_shuffle;

  localparam int unsigned WAIT_LIMIT = 60; // cycles a single wait may take

  logic                                   clk, rst_n;
  logic                                   rst_req = 1'b0;
  logic                                   fetch_valid = 1'b0, branch = 1'b0, ready = 1'b0;
  logic [riscv_isa_pkg::XLEN-1:0]         fetch_instr = '0, fetch_addr = '0;
  logic                                   fetch_ready, valid;
  logic [riscv_isa_pkg::XLEN-1:0]         rdata, addr;
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] rd_phys, rs1_phys, rs2_phys;

  // reference model of accepted instructions in order plus a shadow rename table
  logic [riscv_isa_pkg::XLEN-1:0]         q_instr[$], q_addr[$];
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] q_rd[$], q_rs1[$], q_rs2[$];
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] shadow_map [riscv_isa_pkg::NUM_LOGICAL_REGS];
  logic [shuffle_buf_pkg::NUM_PHYS_REGS-1:0] shadow_rsv;
  logic [riscv_isa_pkg::XLEN-1:0]         last_cf_addr = '0; // pc of the held instr
  int unsigned                            m_count;
  logic                                   m_hold, m_popped, m_full, m_pop, m_resolved;
  logic                                   exp_ready, exp_valid;
  logic [riscv_isa_pkg::XLEN-1:0]         exp_rdata, exp_addr;
  logic [shuffle_buf_pkg::PHYS_IDX_W-1:0] exp_rd, exp_rs1, exp_rs2;

  logic                           rand_ready = 1'b0; // random back-pressure on ready_i
  logic [riscv_isa_pkg::XLEN-1:0] next_addr = 32'h0000_1000;
  int unsigned                    err_cnt = 0, err_mark = 0, tests_run = 0, tests_bad = 0;

  tb_clk_gen clk_gen_inst (.rst_req_i(rst_req), .clk_o(clk), .rst_no(rst_n));

  fetch_shuffle_top fetch_shuffle_top_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .fetch_valid_i (fetch_valid), .fetch_instr_i (fetch_instr), .fetch_addr_i (fetch_addr),
    .fetch_ready_o (fetch_ready), .branch_i (branch), .ready_i (ready),
    .valid_o (valid), .rdata_o (rdata), .addr_o (addr),
    .rd_phys_o (rd_phys), .rs1_phys_o (rs1_phys), .rs2_phys_o (rs2_phys)
  );

  function automatic logic [31:0] encode(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, opc}; // funct3 0, immediates 0
  endfunction

  function automatic logic [31:0] random_plain(); // never control flow
    logic [6:0] opc;
    case ($urandom_range(2, 0))
      0:       opc = riscv_isa_pkg::OPC_OP;
      1:       opc = riscv_isa_pkg::OPC_STORE;
      default: opc = riscv_isa_pkg::OPC_LUI;
    endcase
    return encode(opc, 5'($urandom), 5'($urandom), 5'($urandom));
  endfunction

  function automatic void classify_instr(input logic [31:0] w, output logic cf,
                                         output logic hrd, output logic hrs1,
                                         output logic hrs2);
    logic [6:0] op;
    logic       sys, priv, csr_imm;
    op      = w[6:0];
    sys     = (op == riscv_isa_pkg::OPC_SYSTEM);
    priv    = sys && (w[14:12] == riscv_isa_pkg::F3_PRIV);
    csr_imm = sys && w[14] && (w[13:12] != 2'b00); // csrrwi, csrrsi, csrrci
    cf   = priv || (op == riscv_isa_pkg::OPC_JAL) || (op == riscv_isa_pkg::OPC_JALR) ||
           (op == riscv_isa_pkg::OPC_BRANCH) || (op == riscv_isa_pkg::OPC_FENCE);
    hrd  = !(priv || (op == riscv_isa_pkg::OPC_BRANCH) || (op == riscv_isa_pkg::OPC_STORE) ||
             (op == riscv_isa_pkg::OPC_FENCE));
    hrs1 = !(priv || csr_imm || (op == riscv_isa_pkg::OPC_LUI) ||
             (op == riscv_isa_pkg::OPC_AUIPC) || (op == riscv_isa_pkg::OPC_JAL) ||
             (op == riscv_isa_pkg::OPC_FENCE));
    hrs2 = (op == riscv_isa_pkg::OPC_BRANCH) || (op == riscv_isa_pkg::OPC_STORE) ||
           (op == riscv_isa_pkg::OPC_OP);
  endfunction

  function automatic logic [5:0] lowest_free(input logic [63:0] busy);
    for (int p = 0; p < shuffle_buf_pkg::NUM_PHYS_REGS; p++) begin
      if (!busy[p]) return p[5:0];
    end
    return '0;
  endfunction

  always_comb begin
    m_full     = (m_count == shuffle_buf_pkg::DEPTH);
    exp_valid  = m_full || (m_count != 0 && m_hold); // full, or partial behind a branch
    m_pop      = ready && exp_valid;
    m_resolved = m_popped && ready; // held instr gone and decode took no redirect
    exp_ready  = fetch_valid && !branch && (!m_full || m_pop) && (!m_hold || m_resolved);
  end

  always @(posedge clk or negedge rst_n) begin : ref_model
    logic [63:0] busy;
    logic        cf, hrd, hrs1, hrs2;
    logic [5:0]  n_rd, n_rs1, n_rs2;
    logic [4:0]  lrd;
    if (!rst_n) begin
      q_instr.delete();
      q_addr.delete();
      q_rd.delete();
      q_rs1.delete();
      q_rs2.delete();
      for (int i = 0; i < riscv_isa_pkg::NUM_LOGICAL_REGS; i++) shadow_map[i] = i[5:0];
      shadow_rsv = {32'h0, 32'hffff_ffff}; // x0..x31 sit on their own numbers
      m_count  <= 0;
      m_hold   <= 1'b0;
      m_popped <= 1'b0;
    end else begin
      classify_instr(fetch_instr, cf, hrd, hrs1, hrs2);
      busy = shadow_rsv;
      for (int k = 0; k < q_rd.size(); k++) begin // buffered readers still block reuse
        busy[q_rd[k]]  = 1'b1;
        busy[q_rs1[k]] = 1'b1;
        busy[q_rs2[k]] = 1'b1;
      end
      n_rs1 = hrs1 ? shadow_map[fetch_instr[riscv_isa_pkg::RS1_LSB +: 5]] : '0;
      n_rs2 = hrs2 ? shadow_map[fetch_instr[riscv_isa_pkg::RS2_LSB +: 5]] : '0;
      lrd   = fetch_instr[riscv_isa_pkg::RD_LSB +: 5];
      n_rd  = '0;
      if (exp_ready && hrd && lrd != 5'd0) begin
        n_rd = lowest_free(busy);
        shadow_rsv[shadow_map[lrd]] = 1'b0;
        shadow_rsv[n_rd]            = 1'b1;
        shadow_map[lrd]             = n_rd;
      end
      m_popped <= m_pop && m_hold && (q_addr[0] == last_cf_addr);
      if (m_pop) begin
        void'(q_instr.pop_front());
        void'(q_addr.pop_front());
        void'(q_rd.pop_front());
        void'(q_rs1.pop_front());
        void'(q_rs2.pop_front());
      end
      if (exp_ready) begin
        q_instr.push_back(fetch_instr);
        q_addr.push_back(fetch_addr);
        q_rd.push_back(n_rd);
        q_rs1.push_back(n_rs1);
        q_rs2.push_back(n_rs2);
        if (cf) last_cf_addr = fetch_addr;
      end
      if (exp_ready && !m_pop) m_count <= m_count + 1;
      else if (!exp_ready && m_pop) m_count <= m_count - 1;
      if (exp_ready && cf) m_hold <= 1'b1; // set wins over clear
      else if (branch || m_resolved) m_hold <= 1'b0;
      if (q_instr.size() != 0) begin
        exp_rdata <= q_instr[0];
        exp_addr  <= q_addr[0];
        exp_rd    <= q_rd[0];
        exp_rs1   <= q_rs1[0];
        exp_rs2   <= q_rs2[0];
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_cnt++;
    $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) fetch_ready == exp_ready)
    else report_mismatch("fetch_ready_o", 32'($sampled(fetch_ready)), 32'($sampled(exp_ready)));
  assert property (@(posedge clk) disable iff (!rst_n) valid == exp_valid)
    else report_mismatch("valid_o", 32'($sampled(valid)), 32'($sampled(exp_valid)));
  assert property (@(posedge clk) disable iff (!rst_n) valid |-> rdata == exp_rdata)
    else report_mismatch("rdata_o", $sampled(rdata), $sampled(exp_rdata));
  assert property (@(posedge clk) disable iff (!rst_n) valid |-> addr == exp_addr)
    else report_mismatch("addr_o", $sampled(addr), $sampled(exp_addr));
  assert property (@(posedge clk) disable iff (!rst_n) valid |-> rd_phys == exp_rd)
    else report_mismatch("rd_phys_o", 32'($sampled(rd_phys)), 32'($sampled(exp_rd)));
  assert property (@(posedge clk) disable iff (!rst_n) valid |-> rs1_phys == exp_rs1)
    else report_mismatch("rs1_phys_o", 32'($sampled(rs1_phys)), 32'($sampled(exp_rs1)));
  assert property (@(posedge clk) disable iff (!rst_n) valid |-> rs2_phys == exp_rs2)
    else report_mismatch("rs2_phys_o", 32'($sampled(rs2_phys)), 32'($sampled(exp_rs2)));

  task automatic wait_reset_release();
    int unsigned t;
    t = 0;
    while (!rst_n && t < WAIT_LIMIT) begin
      @(posedge clk);
      t++;
    end
    #5;
    if (!rst_n) begin
      err_cnt++;
      $display("timeout: reset was never released");
    end
  endtask

  task automatic apply_reset();
    rst_req = 1'b1;
    #1;
    rst_req = 1'b0;
    wait_reset_release();
  endtask

  // offer one instruction until fetch_ready_o takes it
  task automatic offer(input logic [31:0] instr);
    int unsigned t;
    logic        taken;
    fetch_valid = 1'b1;
    fetch_instr = instr;
    fetch_addr  = next_addr;
    taken       = 1'b0;
    t           = 0;
    while (!taken && t < WAIT_LIMIT) begin
      if (rand_ready) begin
        ready = ($urandom_range(3, 0) != 0); // about one gap in four
      end
      #1;
      taken = fetch_ready; // settled value just before the edge
      @(posedge clk);
      #5;
      t++;
    end
    fetch_valid = 1'b0;
    if (!taken) begin
      err_cnt++;
      $display("timeout: instruction at %h was never accepted", next_addr);
    end
    next_addr += 4;
  endtask

  task automatic present(input logic [31:0] instr, input int unsigned cycles);
    fetch_valid = 1'b1;
    fetch_instr = instr;
    fetch_addr  = next_addr; // same pc is offered again later
    repeat (cycles) begin
      @(posedge clk);
      #5;
    end
    fetch_valid = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt == err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  initial begin
    void'($urandom(32'h5ab0));
    wait_reset_release();

    ready = 1'b1;
    offer(encode(riscv_isa_pkg::OPC_OP, 5'd1, 5'd2, 5'd3));
    offer(encode(riscv_isa_pkg::OPC_LUI, 5'd4, 5'd0, 5'd0));
    finish_test("reset and first intake");

    rand_ready = 1'b1;
    repeat (20) offer(random_plain());
    rand_ready = 1'b0;
    finish_test("stream order under back-pressure");

    apply_reset();
    ready = 1'b0;
    offer(encode(riscv_isa_pkg::OPC_OP, 5'd4, 5'd5, 5'd6));
    offer(encode(riscv_isa_pkg::OPC_STORE, 5'd0, 5'd7, 5'd8));
    offer(encode(riscv_isa_pkg::OPC_BRANCH, 5'd0, 5'd1, 5'd2)); // intake stops here
    present(encode(riscv_isa_pkg::OPC_OP, 5'd9, 5'd1, 5'd1), 4);
    branch = 1'b1;
    @(posedge clk);
    #5;
    branch = 1'b0;
    offer(encode(riscv_isa_pkg::OPC_OP, 5'd9, 5'd1, 5'd1));
    finish_test("hold after branch and redirect");

    ready = 1'b1;
    offer(encode(riscv_isa_pkg::OPC_JAL, 5'd1, 5'd0, 5'd0));
    offer(encode(riscv_isa_pkg::OPC_OP, 5'd10, 5'd1, 5'd2)); // taken once the jal retires
    finish_test("resume after fall-through");

    apply_reset();
    ready = 1'b0;
    offer(encode(riscv_isa_pkg::OPC_OP, 5'd5, 5'd3, 5'd4));    // rd 32 and identity sources
    offer(encode(riscv_isa_pkg::OPC_OP, 5'd6, 5'd5, 5'd7));    // rd takes freed 5, rs1 reads 32
    offer(encode(riscv_isa_pkg::OPC_OP, 5'd0, 5'd1, 5'd2));    // x0 keeps physical 0
    offer(encode(riscv_isa_pkg::OPC_STORE, 5'd0, 5'd5, 5'd6)); // no rd
    offer(encode(riscv_isa_pkg::OPC_LUI, 5'd8, 5'd0, 5'd0));   // no sources
    ready = 1'b1;
    repeat (shuffle_buf_pkg::DEPTH) offer(random_plain()); // pushes the entries out
    finish_test("register renaming");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* flist.f */
source/riscv_isa_pkg.sv
source/shuffle_buf_pkg.sv
source/instr_class_decode.sv
source/branch_hold_ctrl.sv
source/inst_ring_buffer.sv
source/reg_rename.sv
source/fetch_shuffle_top.sv
dv/tb_clk_gen.sv
dv/tb_fetch_shuffle.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_shuffle
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
